//--- source/zx_video_pkg.sv
package zx_video_pkg;

	typedef enum logic [1:0] {
		timing_pent = 2'b00,
		timing_s128 = 2'b01,
		timing_s48  = 2'b11
	} timing_mode_t;

	typedef logic [8:0]  hcount_t;
	typedef logic [8:0]  vcount_t;
	typedef logic [1:0]  hsub_t;
	typedef logic [7:0]  byte_t;
	typedef logic [12:0] vaddr_t;
	typedef logic [2:0]  border_t; // g, r, b

	localparam int H_AREA       = 256;
	localparam int V_AREA       = 192;
	localparam int SCREEN_DELAY = 8;
	localparam int ATTR_BASE    = 6144;

	localparam int H_LBORDER_S48  = 48 - SCREEN_DELAY;
	localparam int H_RBORDER_S48  = 48 + SCREEN_DELAY;
	localparam int H_BLANK1_S48   = 17;
	localparam int H_SYNC_S48     = 33;
	localparam int H_BLANK2_S48   = 46;
	localparam int V_BBORDER_S48  = 56;
	localparam int V_SYNC_S48     = 8;
	localparam int V_TBORDER_S48  = 56;

	localparam int H_LBORDER_S128 = 48 - SCREEN_DELAY;
	localparam int H_RBORDER_S128 = 48 + SCREEN_DELAY;
	localparam int H_BLANK1_S128  = 25;
	localparam int H_SYNC_S128    = 33;
	localparam int H_BLANK2_S128  = 46;
	localparam int V_BBORDER_S128 = 55;
	localparam int V_SYNC_S128    = 8;
	localparam int V_TBORDER_S128 = 56;

	localparam int H_LBORDER_PENT = 54 - SCREEN_DELAY;
	localparam int H_RBORDER_PENT = 53 + SCREEN_DELAY;
	localparam int H_BLANK1_PENT  = 12;
	localparam int H_SYNC_PENT    = 33;
	localparam int H_BLANK2_PENT  = 40;
	localparam int V_BBORDER_PENT = 56;
	localparam int V_SYNC_PENT    = 8;
	localparam int V_TBORDER_PENT = 64;

	localparam int H_TOTAL_S48  = H_AREA + H_RBORDER_S48 + H_BLANK1_S48 + H_SYNC_S48
		+ H_BLANK2_S48 + H_LBORDER_S48; // 448
	localparam int H_TOTAL_S128 = H_AREA + H_RBORDER_S128 + H_BLANK1_S128 + H_SYNC_S128
		+ H_BLANK2_S128 + H_LBORDER_S128; // 456
	localparam int H_TOTAL_PENT = H_AREA + H_RBORDER_PENT + H_BLANK1_PENT + H_SYNC_PENT
		+ H_BLANK2_PENT + H_LBORDER_PENT; // 448
	localparam int V_TOTAL_S48  = V_AREA + V_BBORDER_S48 + V_SYNC_S48 + V_TBORDER_S48;
	localparam int V_TOTAL_S128 = V_AREA + V_BBORDER_S128 + V_SYNC_S128 + V_TBORDER_S128;
	localparam int V_TOTAL_PENT = V_AREA + V_BBORDER_PENT + V_SYNC_PENT + V_TBORDER_PENT;

	typedef struct packed {
		hcount_t hc;
		vcount_t vc;
		hsub_t   sub;
		logic    screen_load;
		logic    screen_show;
		logic    screen_update;
		logic    border_update;
		logic    bitmap_shift;
		logic    blank;
		logic    hsync;
		logic    vsync;
	} raster_t;

	typedef struct packed {
		logic  n_iorq;
		logic  n_rd;
		logic  n_wr;
		logic  a0;
		byte_t wdata;
	} io_bus_t;

	typedef struct packed {
		logic [1:0] g; // bright in bit 0
		logic [1:0] r;
		logic [1:0] b;
	} rgb_t;

	typedef struct packed {
		logic  pixel;
		byte_t attr;
	} pixel_out_t;

endpackage

//--- source/raster_timing.sv
`timescale 1ns/1ps

module raster_timing import zx_video_pkg::*; (
	input  logic         clk28,
	input  logic         rst_n0,
	input  timing_mode_t timings,
	output raster_t      raster
);

	logic [10:0] hc0; // hc and sub together
	vcount_t     vc;
	hcount_t     hc;

	logic [10:0] hc0_last;
	vcount_t     vc_last;
	hcount_t     hs_start, hs_end;
	hcount_t     hb_start, hb_end;
	vcount_t     vs_start, vs_end;

	logic hc0_reset, vc_reset;
	logic screen_show;

	always_comb begin
		case (timings)
			timing_pent: begin
				hc0_last = 11'(H_TOTAL_PENT * 4 - 1);
				vc_last  = vcount_t'(V_TOTAL_PENT - 1);
				hb_start = hcount_t'(H_AREA + H_RBORDER_PENT);
				hs_start = hcount_t'(H_AREA + H_RBORDER_PENT + H_BLANK1_PENT);
				hs_end   = hcount_t'(H_AREA + H_RBORDER_PENT + H_BLANK1_PENT + H_SYNC_PENT);
				hb_end   = hcount_t'(H_TOTAL_PENT - H_LBORDER_PENT);
				vs_start = vcount_t'(V_AREA + V_BBORDER_PENT);
				vs_end   = vcount_t'(V_AREA + V_BBORDER_PENT + V_SYNC_PENT);
			end
			timing_s128: begin
				hc0_last = 11'(H_TOTAL_S128 * 4 - 1);
				vc_last  = vcount_t'(V_TOTAL_S128 - 1);
				hb_start = hcount_t'(H_AREA + H_RBORDER_S128);
				hs_start = hcount_t'(H_AREA + H_RBORDER_S128 + H_BLANK1_S128);
				hs_end   = hcount_t'(H_AREA + H_RBORDER_S128 + H_BLANK1_S128 + H_SYNC_S128);
				hb_end   = hcount_t'(H_TOTAL_S128 - H_LBORDER_S128);
				vs_start = vcount_t'(V_AREA + V_BBORDER_S128);
				vs_end   = vcount_t'(V_AREA + V_BBORDER_S128 + V_SYNC_S128);
			end
			default: begin // 48k, also the unused code
				hc0_last = 11'(H_TOTAL_S48 * 4 - 1);
				vc_last  = vcount_t'(V_TOTAL_S48 - 1);
				hb_start = hcount_t'(H_AREA + H_RBORDER_S48);
				hs_start = hcount_t'(H_AREA + H_RBORDER_S48 + H_BLANK1_S48);
				hs_end   = hcount_t'(H_AREA + H_RBORDER_S48 + H_BLANK1_S48 + H_SYNC_S48);
				hb_end   = hcount_t'(H_TOTAL_S48 - H_LBORDER_S48);
				vs_start = vcount_t'(V_AREA + V_BBORDER_S48);
				vs_end   = vcount_t'(V_AREA + V_BBORDER_S48 + V_SYNC_S48);
			end
		endcase
	end

	assign hc0_reset = hc0 == hc0_last;
	assign vc_reset  = vc == vc_last;
	assign hc        = hc0[10:2];

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			hc0 <= '0;
			vc  <= '0;
		end else if (hc0_reset) begin
			hc0 <= '0;
			vc  <= vc_reset ? '0 : vc + 1'b1;
		end else begin
			hc0 <= hc0 + 1'b1;
		end
	end

	// display window runs two clocks ahead of the delayed screen
	assign screen_show = (vc < V_AREA) && (hc0 >= SCREEN_DELAY * 4 - 2)
		&& (hc0 < (H_AREA + SCREEN_DELAY) * 4 - 2);

	always_comb begin
		raster.hc            = hc;
		raster.vc            = vc;
		raster.sub           = hc0[1:0];
		raster.screen_load   = (vc < V_AREA) && (hc < H_AREA || hc0_reset);
		raster.screen_show   = screen_show;
		raster.screen_update = (vc < V_AREA) && (hc < H_AREA) && hc0[4:0] == 5'b11110;
		raster.border_update = !screen_show
			&& ((timings == timing_pent && hc0[1:0] == 2'b11) || hc0[4:0] == 5'b11110);
		raster.bitmap_shift  = hc0[1:0] == 2'b10;
		raster.hsync         = hc >= hs_start && hc < hs_end;
		raster.vsync         = vc >= vs_start && vc < vs_end;
		raster.blank         = raster.vsync || (hc >= hb_start && hc < hb_end);
	end

endmodule

//--- source/screen_fetch.sv
`timescale 1ns/1ps

module screen_fetch import zx_video_pkg::*; (
	input  logic    clk28,
	input  logic    rst_n0,
	input  raster_t raster,
	output logic    n_vrd,
	output vaddr_t  va,
	output logic    bitmap_take,
	output logic    attr_take
);

	logic   slot0;
	logic   bitmap_rd, attr_rd; // request in this clock
	logic   rd_bitmap, rd_attr; // strobe on the bus
	vaddr_t bitmap_addr;
	vaddr_t attr_addr;

	// first sub-slot of pixel 0 and pixel 1 in each cell
	assign slot0     = raster.screen_load && raster.sub == 2'd0;
	assign bitmap_rd = slot0 && raster.hc[2:0] == 3'd0;
	assign attr_rd   = slot0 && raster.hc[2:0] == 3'd1;

	// third, pixel row, char row, column
	assign bitmap_addr = {raster.vc[7:6], raster.vc[2:0], raster.vc[5:3], raster.hc[7:3]};
	assign attr_addr   = vaddr_t'(ATTR_BASE) + vaddr_t'({raster.vc[7:3], raster.hc[7:3]});

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			rd_bitmap   <= 1'b0;
			rd_attr     <= 1'b0;
			bitmap_take <= 1'b0;
			attr_take   <= 1'b0;
		end else begin
			rd_bitmap   <= bitmap_rd;
			rd_attr     <= attr_rd;
			bitmap_take <= rd_bitmap; // vd valid one clock after strobe
			attr_take   <= rd_attr;
		end
	end

	always_ff @(posedge clk28) begin
		if (bitmap_rd) begin
			va <= bitmap_addr;
		end else if (attr_rd) begin
			va <= attr_addr;
		end
	end

	assign n_vrd = !(rd_bitmap || rd_attr);

endmodule

//--- source/pixel_shifter.sv
`timescale 1ns/1ps

module pixel_shifter import zx_video_pkg::*; (
	input  logic       clk28,
	input  logic       rst_n0,
	input  raster_t    raster,
	input  byte_t      vd,
	input  logic       bitmap_take,
	input  logic       attr_take,
	input  border_t    border,
	output pixel_out_t pix
);

	byte_t bitmap_next, attr_next; // fetched for the next cell
	byte_t bitmap, attr;           // cell being shifted out
	byte_t attr_border;

	// border shows as paper, no bright, no flash
	assign attr_border = {2'b00, border, 3'b000};

	always_ff @(posedge clk28) begin
		if (bitmap_take) begin
			bitmap_next <= vd;
		end
		if (attr_take) begin
			attr_next <= vd;
		end
	end

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			bitmap <= '0;
			attr   <= '0;
		end else begin
			if (raster.border_update) begin
				attr <= attr_border;
			end else if (raster.screen_update) begin
				attr <= attr_next;
			end

			if (raster.screen_update) begin
				bitmap <= bitmap_next;
			end else if (raster.bitmap_shift) begin
				bitmap <= {bitmap[6:0], 1'b0}; // msb first
			end
		end
	end

	assign pix.pixel = bitmap[7];
	assign pix.attr  = attr;

endmodule

//--- source/video_dac.sv
`timescale 1ns/1ps

module video_dac import zx_video_pkg::*; (
	input  logic       clk28,
	input  logic       rst_n0,
	input  raster_t    raster,
	input  pixel_out_t pix,
	output rgb_t       rgb,
	output logic       hsync,
	output logic       vsync,
	output logic       csync
);

	border_t colour; // g, r, b high bits
	logic    bright;

	assign colour = pix.pixel ? pix.attr[2:0] : pix.attr[5:3]; // ink or paper
	assign bright = pix.attr[6];

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			rgb   <= '0;
			hsync <= 1'b0;
			vsync <= 1'b0;
			csync <= 1'b1;
		end else begin
			if (raster.blank) begin
				rgb <= '0;
			end else begin
				rgb.g <= {colour[2], colour[2] & bright};
				rgb.r <= {colour[1], colour[1] & bright};
				rgb.b <= {colour[0], colour[0] & bright};
			end
			hsync <= raster.hsync;
			vsync <= raster.vsync;
			csync <= ~(raster.hsync ^ raster.vsync);
		end
	end

endmodule

//--- source/port_fe.sv
`timescale 1ns/1ps

module port_fe import zx_video_pkg::*; (
	input  logic       clk28,
	input  logic       rst_n0,
	input  io_bus_t    io,
	input  logic [4:0] kd,
	input  logic       tape_in,
	output border_t    border,
	output byte_t      rd_data,
	output logic       rd_en
);

	logic       fe_cs;
	logic [4:0] kd0; // registered key lines

	// only a0 is decoded, as on the real machine
	assign fe_cs = !io.n_iorq && !io.a0;

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			border <= '0;
		end else if (fe_cs && !io.n_wr) begin
			border <= io.wdata[2:0];
		end
	end

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			rd_en <= 1'b0;
			kd0   <= 5'b11111;
		end else begin
			rd_en <= fe_cs && !io.n_rd;
			kd0   <= kd;
		end
	end

	assign rd_data = {1'b1, tape_in, 1'b1, kd0};

endmodule

//--- source/zx_video_top.sv
`timescale 1ns/1ps

module zx_video_top import zx_video_pkg::*; (
	input  logic         clk28,
	input  logic         rst_n0,
	input  timing_mode_t timings,
	input  io_bus_t      io,
	input  logic [4:0]   kd,
	input  logic         tape_in,
	input  byte_t        vd,
	output logic         n_vrd,
	output vaddr_t       va,
	output byte_t        rd_data,
	output logic         rd_en,
	output rgb_t         rgb,
	output logic         hsync,
	output logic         vsync,
	output logic         csync
);

	raster_t    raster;
	pixel_out_t pix;
	border_t    border;
	logic       bitmap_take;
	logic       attr_take;

	raster_timing u_raster_timing (
		.clk28   (clk28),
		.rst_n0  (rst_n0),
		.timings (timings),
		.raster  (raster)
	);

	screen_fetch u_screen_fetch (
		.clk28       (clk28),
		.rst_n0      (rst_n0),
		.raster      (raster),
		.n_vrd       (n_vrd),
		.va          (va),
		.bitmap_take (bitmap_take),
		.attr_take   (attr_take)
	);

	pixel_shifter u_pixel_shifter (
		.clk28       (clk28),
		.rst_n0      (rst_n0),
		.raster      (raster),
		.vd          (vd),
		.bitmap_take (bitmap_take),
		.attr_take   (attr_take),
		.border      (border),
		.pix         (pix)
	);

	video_dac u_video_dac (
		.clk28  (clk28),
		.rst_n0 (rst_n0),
		.raster (raster),
		.pix    (pix),
		.rgb    (rgb),
		.hsync  (hsync),
		.vsync  (vsync),
		.csync  (csync)
	);

	port_fe u_port_fe (
		.clk28   (clk28),
		.rst_n0  (rst_n0),
		.io      (io),
		.kd      (kd),
		.tape_in (tape_in),
		.border  (border),
		.rd_data (rd_data),
		.rd_en   (rd_en)
	);

endmodule

//--- test/tb_screen_memory.sv
`timescale 1ns/1ps

module tb_screen_memory import zx_video_pkg::*; (
	input  logic   clk28,
	input  logic   rst_n0,
	input  logic   n_vrd,
	input  vaddr_t va,
	output byte_t  vd
);

	localparam byte_t BITMAP_BYTE = 8'hF0;
	localparam byte_t ATTR_BYTE   = {1'b0, 1'b1, 3'd5, 3'd2}; // flash, bright, paper, ink

	// answers a strobe on the edge that ends it
	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			vd <= '0;
		end else if (!n_vrd) begin
			vd <= (va < ATTR_BASE) ? BITMAP_BYTE : ATTR_BYTE;
		end
	end

endmodule

//--- test/tb_zx_video.sv
`timescale 1ns/1ps

module tb_zx_video import zx_video_pkg::*; ();

	typedef struct packed {
		timing_mode_t mode;
		border_t      border;
		logic [4:0]   kd;
		logic         tape;
		logic [15:0]  h_total; // pixels per line
		logic [15:0]  v_total; // lines per frame
		logic [15:0]  h_blank; // blanked pixels per line
	} stim_row_t;

	localparam int      ROWS         = 3;
	localparam rgb_t    INK_BRIGHT   = 6'b00_11_00; // red
	localparam rgb_t    PAPER_BRIGHT = 6'b11_00_11; // cyan
	localparam io_bus_t IO_IDLE      = '{1'b1, 1'b1, 1'b1, 1'b1, 8'h00};

	logic         clk28 = 1'b0;
	logic         rst_n0;
	timing_mode_t timings;
	io_bus_t      io;
	logic [4:0]   kd;
	logic         tape_in;
	byte_t        vd, rd_data;
	logic         n_vrd, rd_en, hsync, vsync, csync;
	vaddr_t       va;
	rgb_t         rgb;

	stim_row_t rows [ROWS];
	int        seed, errors, tests_run, tests_failed;
	logic      timed_out;

	always #10 clk28 = ~clk28;

	zx_video_top uut (
		.clk28 (clk28), .rst_n0 (rst_n0), .timings (timings), .io (io), .kd (kd),
		.tape_in (tape_in), .vd (vd), .n_vrd (n_vrd), .va (va), .rd_data (rd_data),
		.rd_en (rd_en), .rgb (rgb), .hsync (hsync), .vsync (vsync), .csync (csync)
	);

	tb_screen_memory mem (.clk28 (clk28), .rst_n0 (rst_n0), .n_vrd (n_vrd), .va (va), .vd (vd));

	task automatic next_cycle();
		@(posedge clk28);
		#2; // drive and sample point
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		timed_out = 1'b1;
	endtask

	task automatic check_value(input string what, input int got, input int expected);
		assert (got == expected) else begin
			$display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
			errors++;
		end
	endtask

	task automatic close_test(input int r, input string name, input int mark);
		tests_run++;
		if (errors != mark) begin
			tests_failed++;
		end
		$display("row %0d, %s: %s", r, name, (errors == mark) ? "ok" : "fail");
	endtask

	function automatic logic sync_level(input logic sel);
		return sel ? vsync : hsync;
	endfunction

	// clocks from the call up to the first cycle of the new pulse
	task automatic wait_sync_rise(input logic sel, input int limit, output int clocks);
		logic prev;
		prev   = 1'b1; // a level already high is no rise
		clocks = 0;
		while (!(sync_level(sel) && !prev) && !timed_out) begin
			if (clocks == limit) begin
				report_timeout(sel ? "a vsync rise" : "an hsync rise");
			end else begin
				prev = sync_level(sel);
				next_cycle();
				clocks++;
			end
		end
	endtask

	task automatic run_row(input stim_row_t row, input int r);
		int     mark, clocks, frame_clocks, reads, order_err, addr_err;
		int     screen_lines, border_lines, colour_err, border_err, blank_err, sync_err;
		int     line_ink, line_paper, line_border, line_other;
		logic   line_vsync, expect_attr, prev_h, prev_v;
		vaddr_t last_bitmap;
		rgb_t   border_colour;
		border_colour = {row.border[2], 1'b0, row.border[1], 1'b0, row.border[0], 1'b0};
		rst_n0  = 1'b0;
		timings = row.mode;
		io      = IO_IDLE;
		repeat (5) next_cycle();
		rst_n0 = 1'b1;
		io     = '{1'b0, 1'b1, 1'b0, 1'b0, {5'b0, row.border}}; // out (#FE)
		next_cycle();
		mark    = errors;
		kd      = row.kd;
		tape_in = row.tape;
		io      = '{1'b0, 1'b0, 1'b1, 1'b0, 8'h00}; // in (#FE)
		clocks  = 0;
		while (!rd_en && !timed_out) begin
			if (clocks == 4) begin
				report_timeout("rd_en after a port read");
			end else begin
				next_cycle();
				clocks++;
			end
		end
		check_value("rd_data of port #FE", rd_data, {1'b1, row.tape, 1'b1, row.kd});
		io.a0 = 1'b1;
		next_cycle();
		check_value("rd_en with a0 high", rd_en, 0);
		io = IO_IDLE;
		close_test(r, "keyboard and tape read", mark);
		mark = errors;
		wait_sync_rise(1'b0, row.h_total * 4 + 8, clocks);
		wait_sync_rise(1'b0, row.h_total * 4 + 8, clocks);
		check_value("clocks per line", clocks, row.h_total * 4);
		wait_sync_rise(1'b1, row.h_total * row.v_total * 4 + 8, clocks);
		{reads, order_err, addr_err, screen_lines, border_lines} = 0;
		{colour_err, border_err, blank_err, sync_err, frame_clocks} = 0;
		{line_ink, line_paper, line_border, line_other} = 0;
		{line_vsync, expect_attr, prev_v} = 3'b001;
		prev_h = hsync;
		while (!(vsync && !prev_v) && !timed_out) begin
			if (!n_vrd) begin
				reads++;
				if (va < ATTR_BASE) begin
					order_err += expect_attr;
					last_bitmap = va;
					expect_attr = 1'b1;
				end else begin
					order_err += !expect_attr;
					// char row is third and row within third
					addr_err += va != ATTR_BASE + {last_bitmap[12:11], last_bitmap[7:5]} * 32
						+ last_bitmap[4:0];
					expect_attr = 1'b0;
				end
			end
			case (rgb)
				INK_BRIGHT:    line_ink++;
				PAPER_BRIGHT:  line_paper++;
				border_colour: line_border++;
				6'd0:          ;
				default:       line_other++;
			endcase
			blank_err += (hsync || vsync) && rgb != '0;
			sync_err  += csync != !(hsync ^ vsync);
			line_vsync |= vsync;
			if (hsync && !prev_h) begin // a window spans one hsync to the next
				if (line_ink != 0 || line_paper != 0) begin
					screen_lines++;
					colour_err += line_ink != 512 || line_paper != 512 || line_other != 0;
				end else if (!line_vsync) begin
					border_lines++;
					border_err += line_border != (row.h_total - row.h_blank) * 4 || line_other != 0;
				end
				{line_ink, line_paper, line_border, line_other} = 0;
				line_vsync = 1'b0;
			end
			prev_h = hsync;
			prev_v = vsync;
			next_cycle();
			frame_clocks++;
			if (frame_clocks > row.h_total * row.v_total * 4 + 8)
				report_timeout("the vsync rise that ends the frame");
		end
		check_value("clocks per frame", frame_clocks, row.h_total * row.v_total * 4);
		check_value("cycles with wrong csync", sync_err, 0);
		close_test(r, "line and frame periods", mark);
		mark = errors;
		check_value("read strobes per frame", reads, 12288);
		check_value("reads out of order", order_err, 0);
		check_value("wrong attribute addresses", addr_err, 0);
		close_test(r, "fetch count and addresses", mark);
		mark = errors;
		check_value("lines with screen pixels", screen_lines, 192);
		check_value("screen lines with wrong colour counts", colour_err, 0);
		close_test(r, "screen colours", mark);
		mark = errors;
		check_value("border lines seen", border_lines > 0, 1);
		check_value("border lines with wrong colour", border_err, 0);
		check_value("cycles not black in sync", blank_err, 0);
		close_test(r, "border colour", mark);
	endtask

	initial begin
		seed         = 73;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		timed_out    = 1'b0;
		rst_n0       = 1'b0;
		timings      = timing_s48;
		io           = IO_IDLE;
		kd           = 5'h1f;
		tape_in      = 1'b0;
		rows[0] = '{timing_s48,  3'd1, 5'($random(seed)), 1'b0, 16'd448, 16'd312, 16'd96}; // blue
		rows[1] = '{timing_s128, 3'd6, 5'($random(seed)), 1'b1, 16'd456, 16'd311, 16'd104};
		rows[2] = '{timing_pent, 3'd3, 5'($random(seed)), 1'b0, 16'd448, 16'd320, 16'd85};
		for (int r = 0; r < ROWS && !timed_out; r++) begin
			run_row(rows[r], r);
		end
		$display("tests run %0d, tests failed %0d, failed checks %0d",
			tests_run, tests_failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- flist.f
source/zx_video_pkg.sv
source/raster_timing.sv
source/screen_fetch.sv
source/pixel_shifter.sv
source/video_dac.sv
source/port_fe.sv
source/zx_video_top.sv
test/tb_screen_memory.sv
test/tb_zx_video.sv

//--- Bender.yml
package:
  name: zx_video

sources:
  - target: any(rtl, test)
    files:
      - source/zx_video_pkg.sv
      - source/raster_timing.sv
      - source/screen_fetch.sv
      - source/pixel_shifter.sv
      - source/video_dac.sv
      - source/port_fe.sv
      - source/zx_video_top.sv
  - target: test
    files:
      - test/tb_screen_memory.sv
      - test/tb_zx_video.sv
